/* logic/calc_pkg.sv */
`default_nettype none

package calc_pkg;

  localparam int xlen           = 32;
  localparam int reg_els        = 32;
  localparam int comp_stage_els = 4;

  // Cycles from the reservation register to the completion stage a pipe feeds
  localparam int mul_latency = 3;
  localparam int int_latency = 1;

  typedef logic [xlen-1:0]            word_t;
  typedef logic [$clog2(reg_els)-1:0] reg_addr_t;

  typedef enum logic [3:0]
  {
    op_add  = 4'h0
    , op_sub  = 4'h1
    , op_and  = 4'h2
    , op_or   = 4'h3
    , op_xor  = 4'h4
    , op_slt  = 4'h5
    , op_addi = 4'h6
    , op_andi = 4'h7
    , op_ori  = 4'h8
    , op_xori = 4'h9
    , op_mul  = 4'ha
  } calc_op_e;

  typedef struct packed
  {
    logic      v;
    calc_op_e  op;
    reg_addr_t rd_addr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     imm;
  } dispatch_pkt_t;

  // Operands are already resolved, rs2_data holds the immediate for immediate forms
  typedef struct packed
  {
    logic      v;
    calc_op_e  op;
    reg_addr_t rd_addr;
    logic      w_v;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      int_v;
    logic      mul_v;
  } reservation_t;

  typedef struct packed
  {
    logic  v;
    word_t data;
  } exec_result_t;

  typedef struct packed
  {
    logic      v;
    logic      w_v;
    reg_addr_t rd_addr;
    word_t     rd_data;
  } wb_pkt_t;

  typedef wb_pkt_t [comp_stage_els-1:0] comp_view_t;

endpackage

`default_nettype wire

/* logic/calc_decode.sv */
`default_nettype none

module calc_decode
  (input wire                         clk_i
   , input wire                       rst_n_i

   , input wire calc_pkg::dispatch_pkt_t dispatch_pkt_i
   , input wire calc_pkg::comp_view_t    comp_view_i
   , input wire calc_pkg::wb_pkt_t       wb_pkt_i

   , output calc_pkg::reservation_t      reservation_o
   );

  import calc_pkg::*;

  word_t [reg_els-1:0] rf_r;

  logic  is_mul;
  logic  use_imm;
  word_t rs1_fwd;
  word_t rs2_fwd;

  reservation_t reservation_n;

  // Youngest in-flight producer wins, then the register file
  function automatic word_t resolve_operand
    (input reg_addr_t addr
     , input comp_view_t view
     , input word_t rf_data
     );
    word_t data;
    data = rf_data;
    // Walk oldest to youngest so the youngest match overrides
    for (int i = comp_stage_els-1; i >= 0; i--)
    begin
      if (view[i].v && view[i].w_v && (view[i].rd_addr == addr))
      begin
        data = view[i].rd_data;
      end
    end
    if (addr == '0)
    begin
      data = '0;
    end
    return data;
  endfunction

  // Register file write from the last completion stage
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rf_r <= '0;
    end
    else if (wb_pkt_i.v && wb_pkt_i.w_v)
    begin
      rf_r[wb_pkt_i.rd_addr] <= wb_pkt_i.rd_data;
    end
  end

  always_comb
  begin
    is_mul  = 1'b0;
    use_imm = 1'b0;
    case (dispatch_pkt_i.op)
      op_mul:                            is_mul  = 1'b1;
      op_addi, op_andi, op_ori, op_xori: use_imm = 1'b1;
      default: ;
    endcase
  end

  assign rs1_fwd = resolve_operand(dispatch_pkt_i.rs1_addr, comp_view_i,
                                   rf_r[dispatch_pkt_i.rs1_addr]);
  assign rs2_fwd = resolve_operand(dispatch_pkt_i.rs2_addr, comp_view_i,
                                   rf_r[dispatch_pkt_i.rs2_addr]);

  always_comb
  begin
    reservation_n.v        = dispatch_pkt_i.v;
    reservation_n.op       = dispatch_pkt_i.op;
    reservation_n.rd_addr  = dispatch_pkt_i.rd_addr;
    // Writes to x0 still complete, they just never land
    reservation_n.w_v      = dispatch_pkt_i.v & (dispatch_pkt_i.rd_addr != '0);
    reservation_n.rs1_data = rs1_fwd;
    reservation_n.rs2_data = use_imm ? dispatch_pkt_i.imm : rs2_fwd;
    reservation_n.int_v    = dispatch_pkt_i.v & ~is_mul;
    reservation_n.mul_v    = dispatch_pkt_i.v & is_mul;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      reservation_o <= '0;
    end
    else
    begin
      reservation_o <= reservation_n;
    end
  end

endmodule

`default_nettype wire

/* logic/calc_exec.sv */
`default_nettype none

module calc_exec
  (input wire                        clk_i
   , input wire                      rst_n_i

   , input wire calc_pkg::reservation_t reservation_i

   , output calc_pkg::exec_result_t     int_result_o
   , output calc_pkg::exec_result_t     mul_result_o
   );

  import calc_pkg::*;

  word_t alu_data;
  word_t mul_product;

  // One register per cycle between the integer and multiply completion points
  exec_result_t [mul_latency-int_latency-1:0] mul_stage_r;

  // Integer pipe
  always_comb
  begin
    case (reservation_i.op)
      op_add, op_addi: alu_data = reservation_i.rs1_data + reservation_i.rs2_data;
      op_sub:          alu_data = reservation_i.rs1_data - reservation_i.rs2_data;
      op_and, op_andi: alu_data = reservation_i.rs1_data & reservation_i.rs2_data;
      op_or, op_ori:   alu_data = reservation_i.rs1_data | reservation_i.rs2_data;
      op_xor, op_xori: alu_data = reservation_i.rs1_data ^ reservation_i.rs2_data;
      op_slt:
        alu_data = word_t'($signed(reservation_i.rs1_data) < $signed(reservation_i.rs2_data));
      default:         alu_data = '0;
    endcase
  end

  assign int_result_o = '{v: reservation_i.int_v, data: alu_data};

  // Multiply pipe, low half of the product only
  assign mul_product = reservation_i.rs1_data * reservation_i.rs2_data;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      mul_stage_r <= '0;
    end
    else
    begin
      mul_stage_r[0] <= '{v: reservation_i.mul_v, data: mul_product};
      for (int i = 1; i < mul_latency-int_latency; i++)
      begin
        mul_stage_r[i] <= mul_stage_r[i-1];
      end
    end
  end

  assign mul_result_o = mul_stage_r[mul_latency-int_latency-1];

endmodule

`default_nettype wire

/* logic/calc_result.sv */
`default_nettype none

module calc_result
  (input wire                        clk_i
   , input wire                      rst_n_i

   , input wire calc_pkg::reservation_t reservation_i
   , input wire calc_pkg::exec_result_t int_result_i
   , input wire calc_pkg::exec_result_t mul_result_i

   , output calc_pkg::comp_view_t       comp_view_o
   , output calc_pkg::wb_pkt_t          wb_pkt_o
   );

  import calc_pkg::*;

  // Index is the stage number, stage 0 lives in decode as the reservation
  wb_pkt_t [comp_stage_els:1]   comp_stage_n;
  wb_pkt_t [comp_stage_els-1:1] comp_stage_r;

  // Latencies are static and issue is single, so the merges never collide
  always_comb
  begin
    comp_stage_n[1] = '{v       : reservation_i.v
                        , w_v     : reservation_i.w_v
                        , rd_addr : reservation_i.rd_addr
                        , rd_data : '0
                        };
    for (int i = 2; i <= comp_stage_els; i++)
    begin
      comp_stage_n[i] = comp_stage_r[i-1];
    end

    comp_stage_n[int_latency].rd_data |= int_result_i.v ? int_result_i.data : '0;
    comp_stage_n[mul_latency].rd_data |= mul_result_i.v ? mul_result_i.data : '0;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      comp_stage_r <= '0;
    end
    else
    begin
      comp_stage_r <= comp_stage_n[comp_stage_els-1:1];
    end
  end

  // Stage i forwards what it will hold one stage later
  // the last entry is the writeback stage itself
  assign comp_view_o = comp_stage_n;

  assign wb_pkt_o = comp_stage_r[comp_stage_els-1];

endmodule

`default_nettype wire

/* logic/calc_top.sv */
`default_nettype none

module calc_top
  (input wire                         clk_i
   , input wire                       rst_n_i

   , input wire calc_pkg::dispatch_pkt_t dispatch_pkt_i

   , output calc_pkg::wb_pkt_t           wb_pkt_o
   );

  import calc_pkg::*;

  reservation_t reservation;
  exec_result_t int_result;
  exec_result_t mul_result;
  comp_view_t   comp_view;
  wb_pkt_t      wb_pkt;

  calc_decode calc_decode_i
    (.clk_i(clk_i)
     , .rst_n_i(rst_n_i)
     , .dispatch_pkt_i(dispatch_pkt_i)
     , .comp_view_i(comp_view)
     , .wb_pkt_i(wb_pkt)
     , .reservation_o(reservation)
     );

  // Integer result is combinational, multiply is registered twice
  calc_exec calc_exec_i
    (.clk_i(clk_i)
     , .rst_n_i(rst_n_i)
     , .reservation_i(reservation)
     , .int_result_o(int_result)
     , .mul_result_o(mul_result)
     );

  calc_result calc_result_i
    (.clk_i(clk_i)
     , .rst_n_i(rst_n_i)
     , .reservation_i(reservation)
     , .int_result_i(int_result)
     , .mul_result_i(mul_result)
     , .comp_view_o(comp_view)
     , .wb_pkt_o(wb_pkt)
     );

  assign wb_pkt_o = wb_pkt;

endmodule

`default_nettype wire

/* verif/calc_tests.svh */
`ifndef calc_tests_svh
`define calc_tests_svh

task automatic test_reset();
  test_name = "test_reset";
  repeat (5)
  begin
    @(negedge clk);
    compare_wb(test_name, '0, wb_pkt);
  end
  // Every register still reads zero
  repeat (8)
  begin
    dispatch(op_add, rand_reg(), rand_reg(), rand_reg(), next_rand());
  end
  drain();
endtask

task automatic test_alu_ops();
  calc_op_e ops [10];
  ops = '{op_add, op_sub, op_and, op_or, op_xor, op_slt, op_addi, op_andi, op_ori, op_xori};
  test_name = "test_alu_ops";
  // Loads far enough apart to land in the register file
  for (int r = 1; r <= 8; r++)
  begin
    dispatch(op_addi, reg_addr_t'(r), '0, '0, next_rand());
    idle(4);
  end
  for (int round = 0; round < 2; round++)
  begin
    foreach (ops[k])
    begin
      dispatch(ops[k], reg_addr_t'(10 + k), rand_src(), rand_src(), next_rand());
    end
  end
  drain();
endtask

task automatic test_int_forwarding();
  test_name = "test_int_forwarding";
  // Each step reaches one stage deeper, at distance 5 the value is in the register file
  for (int d = 1; d <= 5; d++)
  begin
    dispatch(op_addi, 5'd21, '0, '0, next_rand());
    idle(d - 1);
    dispatch(op_add, 5'd22, 5'd21, 5'd1, next_rand());
    dispatch(op_sub, 5'd23, 5'd2, 5'd21, next_rand());
  end
  // Several writers of x24 in flight, the youngest must win
  for (int k = 0; k < 6; k++)
  begin
    dispatch(op_addi, 5'd24, 5'd24, '0, next_rand());
  end
  dispatch(op_xor, 5'd25, 5'd24, 5'd1, next_rand());
  drain();
endtask

task automatic test_mul();
  test_name = "test_mul";
  for (int r = 1; r <= 4; r++)
  begin
    dispatch(op_addi, reg_addr_t'(r), '0, '0, next_rand());
  end
  for (int k = 0; k < 6; k++)
  begin
    dispatch(op_mul, 5'd26, rand_src(), rand_src(), next_rand());
    dispatch(op_addi, 5'd27, '0, '0, next_rand());
    dispatch(op_xor, 5'd28, rand_src(), rand_src(), next_rand());
    dispatch(op_add, 5'd29, 5'd26, 5'd27, next_rand());
  end
  // Four multiplies in flight, then a multiply fed by two of them
  for (int r = 11; r <= 14; r++)
  begin
    dispatch(op_mul, reg_addr_t'(r), rand_src(), rand_src(), next_rand());
  end
  idle(2);
  dispatch(op_mul, 5'd30, 5'd11, 5'd14, next_rand());
  drain();
endtask

task automatic test_x0();
  test_name = "test_x0";
  dispatch(op_add, 5'd0, 5'd1, 5'd2, next_rand());
  dispatch(op_mul, 5'd0, 5'd3, 5'd4, next_rand());
  dispatch(op_addi, 5'd0, 5'd0, '0, next_rand());
  // Results aimed at x0 must never be forwarded
  dispatch(op_or, 5'd5, 5'd0, 5'd0, next_rand());
  dispatch(op_ori, 5'd6, 5'd0, '0, next_rand());
  idle(4);
  dispatch(op_add, 5'd7, 5'd0, 5'd0, next_rand());
  drain();
endtask

`endif

/* verif/calc_tb.sv */
`default_nettype none

module calc_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import calc_pkg::*;

  // About five times the length of the full sequence
  localparam int unsigned timeout_cycles = 1000;
  // Edges from the driving edge to the edge that puts the result on wb_pkt
  localparam int unsigned wb_latency     = 4;

  logic          clk;
  logic          rst_n;
  dispatch_pkt_t dispatch_pkt;
  wb_pkt_t       wb_pkt;

  word_t       lcg_state = 32'h5f96_7727;
  word_t       model_rf [reg_els] = '{default: '0};
  int unsigned cycle_cnt = 0;
  string       test_name;

  // Expected writebacks, oldest first
  wb_pkt_t     exp_pkt_q [$];
  int unsigned exp_due_q [$];
  string       exp_name_q [$];

  calc_top calc_top_i
    (.clk_i(clk)
     , .rst_n_i(rst_n)
     , .dispatch_pkt_i(dispatch_pkt)
     , .wb_pkt_o(wb_pkt)
     );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic word_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upper bits only, the low bits of the LCG repeat quickly
  function automatic reg_addr_t rand_src();
    return reg_addr_t'(1 + (next_rand() >> 29));
  endfunction

  function automatic reg_addr_t rand_reg();
    return reg_addr_t'(next_rand() >> 27);
  endfunction

  function automatic word_t read_model(input reg_addr_t addr);
    return (addr == '0) ? '0 : model_rf[addr];
  endfunction

  function automatic word_t expected_result(input calc_op_e opcode, input word_t a, input word_t b);
    case (opcode)
      op_add, op_addi: return a + b;
      op_sub:          return a - b;
      op_and, op_andi: return a & b;
      op_or, op_ori:   return a | b;
      op_xor, op_xori: return a ^ b;
      op_slt:          return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      op_mul:          return a * b;
      default:         return '0;
    endcase
  endfunction

  task automatic stop_on_failure();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic compare_wb(input string name, input wb_pkt_t expected, input wb_pkt_t actual);
    if (expected !== actual)
    begin
      $display("[FAIL] %s: expected v=%0b we=%0b x%0d=%h, actual v=%0b we=%0b x%0d=%h", name,
               expected.v, expected.w_v, expected.rd_addr, expected.rd_data,
               actual.v, actual.w_v, actual.rd_addr, actual.rd_data);
      stop_on_failure();
    end
  endtask

  // Model runs in program order at dispatch time
  task automatic dispatch(input calc_op_e opcode, input reg_addr_t rd, input reg_addr_t rs1,
                          input reg_addr_t rs2, input word_t imm);
    word_t   a;
    word_t   b;
    wb_pkt_t exp_pkt;
    a = read_model(rs1);
    b = (opcode inside {op_addi, op_andi, op_ori, op_xori}) ? imm : read_model(rs2);
    exp_pkt = '{v: 1'b1, w_v: (rd != '0), rd_addr: rd, rd_data: expected_result(opcode, a, b)};
    if (rd != '0)
      model_rf[rd] = exp_pkt.rd_data;
    @(posedge clk);
    dispatch_pkt <= '{v: 1'b1, op: opcode, rd_addr: rd, rs1_addr: rs1, rs2_addr: rs2, imm: imm};
    exp_pkt_q.push_back(exp_pkt);
    exp_due_q.push_back(cycle_cnt + wb_latency);
    exp_name_q.push_back(test_name);
  endtask

  task automatic idle(input int unsigned n);
    repeat (n)
    begin
      @(posedge clk);
      dispatch_pkt <= '0;
    end
  endtask

  task automatic drain();
    idle(1);
    while (exp_pkt_q.size() != 0)
    begin
      idle(1);
    end
  endtask

  `include "calc_tests.svh"

  always @(negedge clk)
  begin
    if (wb_pkt.v && (exp_pkt_q.size() == 0))
    begin
      $display("Writeback to x%0d arrived with nothing outstanding", wb_pkt.rd_addr);
      stop_on_failure();
    end
    else if (wb_pkt.v && (exp_due_q[0] != cycle_cnt))
    begin
      $display("%s: writeback arrived at cycle %0d but was due at cycle %0d",
               exp_name_q[0], cycle_cnt, exp_due_q[0]);
      stop_on_failure();
    end
    else if (wb_pkt.v)
    begin
      compare_wb(exp_name_q.pop_front(), exp_pkt_q.pop_front(), wb_pkt);
      void'(exp_due_q.pop_front());
    end
    else if ((exp_due_q.size() != 0) && (exp_due_q[0] <= cycle_cnt))
    begin
      $display("%s: no writeback by cycle %0d", exp_name_q[0], cycle_cnt);
      stop_on_failure();
    end
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles)
    begin
      $display("Timeout, the run did not finish within %0d cycles", timeout_cycles);
      stop_on_failure();
    end
  end

  initial
  begin
    rst_n        = 1'b0;
    dispatch_pkt = '0;
    test_name    = "reset";
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    test_alu_ops();
    test_int_forwarding();
    test_mul();
    test_x0();
    if (exp_pkt_q.size() == 0)
    begin
      $display("All tests passed!");
      $finish;
    end
    else
    begin
      $display("Writebacks still outstanding at the end of the run");
      stop_on_failure();
    end
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verif
logic/calc_pkg.sv
logic/calc_decode.sv
logic/calc_exec.sv
logic/calc_result.sv
logic/calc_top.sv
verif/calc_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --timescale 1ns/1ps
TB_TOP    ?= calc_tb
RTL_TOP   ?= calc_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TB_TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
